/* itlb_ctrl.sv */
/*
 * Combinational control of the L1 instruction TLB
 * Flush mask, response handshake, exception register and fill strobes
 */

`default_nettype none

module itlb_ctrl import itlb_pkg::*; #(
  parameter int unsigned N_ENTRIES = 8
) (
  input  logic                          tlb_cond_ready_i,
  input  logic                          waiting_i,
  input  flush_e                        flush_type_i,
  input  asid_t                         flush_asid_i,
  input  vpn_t                          flush_page_i,
  input  itlb_entry_t [N_ENTRIES-1:0]   entries_i,
  input  logic                          req_valid_i,
  input  logic                          hit_i,
  input  exception_e                    exception_i,
  input  logic                          l2_resp_valid_i,
  input  exception_e                    l2_resp_exception_i,
  output logic                          flush_o,
  output logic [N_ENTRIES-1:0]          flush_vec_o,
  output logic                          req_ready_o,
  output logic                          resp_valid_o,
  output logic                          exc_reg_en_o,
  output logic                          exc_reg_clr_o,
  output logic                          replace_o
);

  logic [N_ENTRIES-1:0] asid_match;
  logic [N_ENTRIES-1:0] page_match;
  logic                 can_answer;
  logic                 l2_answer;

  always_comb begin
    for (int k = 0; k < N_ENTRIES; k++) begin
      // Global entries survive ASID flushes
      asid_match[k] = (entries_i[k].asid == flush_asid_i) && !entries_i[k].glob;
      // Page compare at the entry's own granularity
      if (entries_i[k].gibi) begin
        page_match[k] = entries_i[k].vpn[2] == flush_page_i[2];
      end else if (entries_i[k].mebi) begin
        page_match[k] = entries_i[k].vpn[2:1] == flush_page_i[2:1];
      end else begin
        page_match[k] = entries_i[k].vpn == flush_page_i;
      end
      case (flush_type_i)
        FlushAll:      flush_vec_o[k] = 1'b1;
        FlushAsid:     flush_vec_o[k] = asid_match[k];
        FlushPage:     flush_vec_o[k] = page_match[k];
        FlushAsidPage: flush_vec_o[k] = asid_match[k] && page_match[k];
        default:       flush_vec_o[k] = 1'b0;
      endcase
    end
  end

  // Flushes only act while idle
  assign flush_o = tlb_cond_ready_i && (flush_type_i != NoFlush);

  // Idle and either a hit or some fault to report
  assign can_answer   = tlb_cond_ready_i && (hit_i || (exception_i != NoException));
  assign req_ready_o  = can_answer;
  assign resp_valid_o = can_answer && req_valid_i;

  // Pending exception is consumed by the response that reports it
  assign exc_reg_clr_o = resp_valid_o && (exception_i != NoException);

  // Second-level answer accepted in the wait state
  assign l2_answer    = waiting_i && l2_resp_valid_i;
  assign replace_o    = l2_answer && (l2_resp_exception_i == NoException);
  assign exc_reg_en_o = l2_answer && (l2_resp_exception_i != NoException);

endmodule

`default_nettype wire

/* itlb_cu.sv */
/*
 * Moore control unit of the L1 instruction TLB
 * Sequences a miss through the second-level request and its answer
 */

`default_nettype none

module itlb_cu import itlb_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic abort_i,
  input  logic vmem_on_i,
  input  logic req_valid_i,
  input  logic vaddr_fault_i,
  input  logic hit_i,
  input  logic l2_req_ready_i,
  input  logic l2_resp_valid_i,
  output logic cond_ready_o,
  output logic l2_req_valid_o,
  output logic l2_resp_ready_o,
  output logic waiting_o
);

  cu_state_e state_q;
  cu_state_e state_d;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CuIdle: begin
        // Only a clean miss goes to the second level
        if (!abort_i && vmem_on_i && req_valid_i && !vaddr_fault_i && !hit_i) begin
          state_d = CuL2Req;
        end
      end
      CuL2Req: begin
        if (abort_i) begin
          state_d = CuIdle;
        end else if (l2_req_ready_i) begin
          state_d = CuL2Wait;
        end
      end
      CuL2Wait: begin
        // Answer taken here since ready is high in this state
        if (abort_i || l2_resp_valid_i) begin
          state_d = CuIdle;
        end
      end
      default: begin
        state_d = CuIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CuIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs from the state alone
  always_comb begin
    cond_ready_o    = 1'b0;
    l2_req_valid_o  = 1'b0;
    l2_resp_ready_o = 1'b0;
    waiting_o       = 1'b0;
    case (state_q)
      CuIdle: begin
        // Hit or fault can be answered at once
        cond_ready_o = 1'b1;
      end
      CuL2Req: begin
        l2_req_valid_o = 1'b1;
      end
      CuL2Wait: begin
        l2_resp_ready_o = 1'b1;
        waiting_o       = 1'b1;
      end
      default: begin
        cond_ready_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* itlb_l1.sv */
/*
 * L1 instruction TLB for Sv39, fully associative
 * Zero-latency hit path for a virtually indexed, physically tagged cache,
 * misses are served by the second-level TLB
 */

`default_nettype none

module itlb_l1 import itlb_pkg::*; #(
  parameter int unsigned N_ENTRIES = 8
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  priv_e        priv_mode_i,
  input  asid_t        base_asid_i,
  input  flush_e       flush_type_i,
  input  asid_t        flush_asid_i,
  input  vpn_t         flush_page_i,
  input  logic         vmem_on_i,
  input  logic         abort_i,
  input  icache_req_t  ic_areq_i,
  output logic         ic_areq_ready_o,
  output icache_resp_t ic_aresp_o,
  output l2_req_t      l2_req_o,
  input  logic         l2_req_ready_i,
  input  l2_resp_t     l2_resp_i,
  output logic         l2_resp_ready_o
);

  localparam int unsigned IDX_W = $clog2(N_ENTRIES);

  // Effective request, zero while translation is off
  logic        req_valid;
  vaddr_t      vaddr;

  // Entry array
  logic [N_ENTRIES-1:0]        valid_q;
  itlb_entry_t [N_ENTRIES-1:0] entry_q;
  itlb_entry_t [N_ENTRIES-1:0] entries;
  itlb_entry_t                 fill_entry;

  // Compare and select
  logic [N_ENTRIES-1:0] page_hit;
  logic [N_ENTRIES-1:0] hit_vec;
  logic [IDX_W-1:0]     hit_idx;
  logic                 hit;
  itlb_entry_t          hit_entry;
  paddr_t               tlb_paddr;

  // Exceptions
  logic       vaddr_fault;
  logic       req_fault;
  logic       perm_fault;
  exception_e exception_q;
  exception_e eff_exception;

  // Control links
  logic                 cond_ready;
  logic                 waiting;
  logic                 l2_req_valid;
  logic                 flush;
  logic [N_ENTRIES-1:0] flush_vec;
  logic                 replace;
  logic [N_ENTRIES-1:0] replace_vec;
  logic                 exc_reg_en;
  logic                 exc_reg_clr;
  logic                 ctrl_ready;
  logic                 ctrl_resp_valid;

  assign req_valid = vmem_on_i ? ic_areq_i.valid : 1'b0;
  assign vaddr     = vmem_on_i ? ic_areq_i.vaddr : '0;

  // Bits 63..39 must all copy bit 38
  assign vaddr_fault = vaddr.upper != {(XLEN-VADDR_LEN){vaddr.vpn[2][VPN_FIELD_LEN-1]}};

  // A reported L2 fault ends the request without starting a new miss
  assign req_fault = vaddr_fault || (exception_q != NoException);

  // Loaded by a faulting second-level answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exception_q <= NoException;
    end else if (exc_reg_clr) begin
      exception_q <= NoException;
    end else if (exc_reg_en) begin
      exception_q <= l2_resp_i.exception;
    end
  end

  // Canonical fault, then L2 fault, then U/S permission
  always_comb begin
    if (vaddr_fault) begin
      eff_exception = PageFault;
    end else if (exception_q != NoException) begin
      eff_exception = exception_q;
    end else if (perm_fault) begin
      eff_exception = PageFault;
    end else begin
      eff_exception = NoException;
    end
  end

  // Valid bits flush and fill, payload only on fill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= valid_q & ~flush_vec;
    end else if (replace) begin
      valid_q <= valid_q | replace_vec;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < N_ENTRIES; k++) begin
      if (replace && replace_vec[k]) begin
        entry_q[k] <= fill_entry;
      end
    end
  end

  // New entry built from the held request and the L2 answer
  always_comb begin
    fill_entry       = '0;
    fill_entry.valid = 1'b1;
    fill_entry.vpn   = vaddr.vpn;
    fill_entry.ppn   = l2_resp_i.ppn;
    fill_entry.asid  = base_asid_i;
    fill_entry.glob  = l2_resp_i.g_bit;
    fill_entry.user  = l2_resp_i.u_bit;
    fill_entry.mebi  = l2_resp_i.page_type == MebiPage;
    fill_entry.gibi  = l2_resp_i.page_type == GibiPage;
  end

  // Compare every entry at its page granularity
  always_comb begin
    hit_idx = '0;
    for (int k = 0; k < N_ENTRIES; k++) begin
      entries[k]       = entry_q[k];
      entries[k].valid = valid_q[k];
      if (entries[k].gibi) begin
        page_hit[k] = vaddr.vpn[2] == entries[k].vpn[2];
      end else if (entries[k].mebi) begin
        page_hit[k] = vaddr.vpn[2:1] == entries[k].vpn[2:1];
      end else begin
        page_hit[k] = vaddr.vpn == entries[k].vpn;
      end
      hit_vec[k] = entries[k].valid && page_hit[k]
                && ((entries[k].asid == base_asid_i) || entries[k].glob);
      if (hit_vec[k]) begin
        hit_idx = IDX_W'(k);
      end
    end
  end

  assign hit       = |hit_vec;
  assign hit_entry = entries[hit_idx];

  // User page from S, or supervisor page from U; M always passes
  assign perm_fault = hit && ((hit_entry.user && (priv_mode_i == S))
                           || (!hit_entry.user && (priv_mode_i == U)));

  // Superpages keep the low VPN fields untranslated
  always_comb begin
    if (hit_entry.gibi) begin
      tlb_paddr = {hit_entry.ppn.p2, vaddr.vpn[1], vaddr.vpn[0], vaddr.page_offset};
    end else if (hit_entry.mebi) begin
      tlb_paddr = {hit_entry.ppn.p2, hit_entry.ppn.p1, vaddr.vpn[0], vaddr.page_offset};
    end else begin
      tlb_paddr = {hit_entry.ppn, vaddr.page_offset};
    end
  end

  // Pass-through while translation is off
  always_comb begin
    if (vmem_on_i) begin
      ic_areq_ready_o      = ctrl_ready;
      ic_aresp_o.valid     = ctrl_resp_valid;
      ic_aresp_o.hit       = hit;
      ic_aresp_o.paddr     = tlb_paddr;
      ic_aresp_o.exception = eff_exception;
    end else begin
      ic_areq_ready_o      = 1'b1;
      ic_aresp_o.valid     = ic_areq_i.valid;
      ic_aresp_o.hit       = 1'b1;
      ic_aresp_o.paddr     = ic_areq_i.vaddr[PADDR_LEN-1:0];
      ic_aresp_o.exception = NoException;
    end
  end

  assign l2_req_o.valid = l2_req_valid;
  assign l2_req_o.vpn   = vaddr.vpn;

  itlb_nru #(
    .N_ENTRIES(N_ENTRIES)
  ) itlb_nru_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_vec_i  (valid_q),
    .hit_vec_i    (hit_vec),
    .req_valid_i  (req_valid),
    .replace_i    (replace),
    .replace_vec_o(replace_vec)
  );

  itlb_cu itlb_cu_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .abort_i        (abort_i),
    .vmem_on_i      (vmem_on_i),
    .req_valid_i    (req_valid),
    .vaddr_fault_i  (req_fault),
    .hit_i          (hit),
    .l2_req_ready_i (l2_req_ready_i),
    .l2_resp_valid_i(l2_resp_i.valid),
    .cond_ready_o   (cond_ready),
    .l2_req_valid_o (l2_req_valid),
    .l2_resp_ready_o(l2_resp_ready_o),
    .waiting_o      (waiting)
  );

  itlb_ctrl #(
    .N_ENTRIES(N_ENTRIES)
  ) itlb_ctrl_i (
    .tlb_cond_ready_i   (cond_ready),
    .waiting_i          (waiting),
    .flush_type_i       (flush_type_i),
    .flush_asid_i       (flush_asid_i),
    .flush_page_i       (flush_page_i),
    .entries_i          (entries),
    .req_valid_i        (req_valid),
    .hit_i              (hit),
    .exception_i        (eff_exception),
    .l2_resp_valid_i    (l2_resp_i.valid),
    .l2_resp_exception_i(l2_resp_i.exception),
    .flush_o            (flush),
    .flush_vec_o        (flush_vec),
    .req_ready_o        (ctrl_ready),
    .resp_valid_o       (ctrl_resp_valid),
    .exc_reg_en_o       (exc_reg_en),
    .exc_reg_clr_o      (exc_reg_clr),
    .replace_o          (replace)
  );

endmodule

`default_nettype wire

/* itlb_nru.sv */
/*
 * Not-recently-used replacement for the L1 instruction TLB
 * Picks the entry that a fill from the second level overwrites
 */

`default_nettype none

module itlb_nru #(
  parameter int unsigned N_ENTRIES = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [N_ENTRIES-1:0] valid_vec_i,
  input  logic [N_ENTRIES-1:0] hit_vec_i,
  input  logic                 req_valid_i,
  input  logic                 replace_i,
  output logic [N_ENTRIES-1:0] replace_vec_o
);

  logic [N_ENTRIES-1:0] use_q;
  logic [N_ENTRIES-1:0] use_d;
  logic [N_ENTRIES-1:0] set_vec;
  logic [N_ENTRIES-1:0] use_set;
  logic                 victim_found;

  // Entries touched this cycle, by a hit or by a fill
  assign set_vec = (hit_vec_i & {N_ENTRIES{req_valid_i}})
                 | (replace_vec_o & {N_ENTRIES{replace_i}});
  assign use_set = use_q | set_vec;

  // On saturation only the newest entries stay marked
  assign use_d = (&use_set) ? set_vec : use_set;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      use_q <= '0;
    end else begin
      use_q <= use_d;
    end
  end

  always_comb begin
    replace_vec_o = '0;
    victim_found  = 1'b0;
    // Free slots are taken first, lowest index wins
    for (int k = 0; k < N_ENTRIES; k++) begin
      if (!valid_vec_i[k] && !victim_found) begin
        replace_vec_o[k] = 1'b1;
        victim_found     = 1'b1;
      end
    end
    // Array full, evict the lowest entry not used lately
    for (int k = 0; k < N_ENTRIES; k++) begin
      if (!use_q[k] && !victim_found) begin
        replace_vec_o[k] = 1'b1;
        victim_found     = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* itlb_pkg.sv */
/*
 * Sv39 instruction TLB definitions
 * Address widths, page and privilege encodings, and the channel structs
 * between the instruction cache, the L1 TLB and the second-level TLB
 */

`default_nettype none

package itlb_pkg;

  // Address widths
  localparam int unsigned XLEN      = 64;
  localparam int unsigned VADDR_LEN = 39;
  localparam int unsigned PADDR_LEN = 56;

  // Sv39 page geometry
  localparam int unsigned PAGE_OFFSET_LEN = 12;
  localparam int unsigned VPN_FIELD_LEN   = 9;
  localparam int unsigned PPN2_LEN        = PADDR_LEN - PAGE_OFFSET_LEN - 2 * VPN_FIELD_LEN;

  typedef logic [15:0]                 asid_t;
  typedef logic [PADDR_LEN-1:0]        paddr_t;
  typedef logic [VPN_FIELD_LEN-1:0]    vpn_field_t;
  typedef logic [PAGE_OFFSET_LEN-1:0]  page_offset_t;
  typedef logic [XLEN-VADDR_LEN-1:0]   vaddr_upper_t;

  // Index 2 is the most significant field
  typedef vpn_field_t [2:0] vpn_t;

  typedef struct packed {
    logic [PPN2_LEN-1:0]      p2;
    logic [VPN_FIELD_LEN-1:0] p1;
    logic [VPN_FIELD_LEN-1:0] p0;
  } ppn_t;

  // Upper bits must repeat bit 38 for a canonical address
  typedef struct packed {
    vaddr_upper_t upper;
    vpn_t         vpn;
    page_offset_t page_offset;
  } vaddr_t;

  // M is never translated
  typedef enum logic [1:0] {U = 2'b00, S = 2'b01, M = 2'b11} priv_e;
  typedef enum logic [1:0] {KibiPage, MebiPage, GibiPage} page_e;
  typedef enum logic [1:0] {NoException, PageFault, AccessFault} exception_e;
  typedef enum logic [2:0] {NoFlush, FlushAll, FlushAsid, FlushPage, FlushAsidPage} flush_e;
  typedef enum logic [1:0] {CuIdle, CuL2Req, CuL2Wait} cu_state_e;

  // Instruction cache channels
  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } icache_req_t;

  typedef struct packed {
    logic       valid;
    logic       hit;
    paddr_t     paddr;
    exception_e exception;
  } icache_resp_t;

  // Second-level TLB channels
  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } l2_req_t;

  typedef struct packed {
    logic       valid;
    ppn_t       ppn;
    page_e      page_type;
    logic       g_bit;
    logic       u_bit;
    exception_e exception;
  } l2_resp_t;

  // One TLB entry, size given by the mebi and gibi flags
  typedef struct packed {
    logic  valid;
    vpn_t  vpn;
    ppn_t  ppn;
    asid_t asid;
    logic  glob;
    logic  user;
    logic  mebi;
    logic  gibi;
  } itlb_entry_t;

endpackage

`default_nettype wire

/* itlb_tb.sv */
/*
 * Testbench of the L1 instruction TLB
 * Random requests over a small page pool, a second-level TLB model,
 * flushes, pass-through and abort, all checked against a translation model
 */

`default_nettype none

module itlb_tb import itlb_pkg::*; ;

  localparam int unsigned N_TRANS = 300;
  localparam int unsigned N_PAGES = 16;

  logic         clk_i;
  logic         rst_ni;
  priv_e        priv_mode;
  asid_t        base_asid;
  flush_e       flush_type;
  asid_t        flush_asid;
  vpn_t         flush_page;
  logic         vmem_on;
  logic         abort;
  icache_req_t  ic_areq;
  logic         ic_areq_ready;
  icache_resp_t ic_aresp;
  l2_req_t      l2_req;
  logic         l2_req_ready;
  l2_resp_t     l2_resp;
  logic         l2_resp_ready;

  logic [31:0] lfsr_q = 32'he037d377;
  int unsigned errors = 0;
  vpn_t        pages [N_PAGES];
  // Second-level model holds its answer until the unit is idle again
  logic        late_mode = 1'b0;
  logic        l2_busy = 1'b0;

  tb_clock #(
    .PERIOD(8)
  ) tb_clock_i (
    .clk_o(clk_i)
  );

  itlb_l1 #(
    .N_ENTRIES(8)
  ) itlb_l1_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .priv_mode_i    (priv_mode),
    .base_asid_i    (base_asid),
    .flush_type_i   (flush_type),
    .flush_asid_i   (flush_asid),
    .flush_page_i   (flush_page),
    .vmem_on_i      (vmem_on),
    .abort_i        (abort),
    .ic_areq_i      (ic_areq),
    .ic_areq_ready_o(ic_areq_ready),
    .ic_aresp_o     (ic_aresp),
    .l2_req_o       (l2_req),
    .l2_req_ready_i (l2_req_ready),
    .l2_resp_i      (l2_resp),
    .l2_resp_ready_o(l2_resp_ready)
  );

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  // Translation rule, a function of the VPN only
  function automatic ppn_t rule_ppn(input vpn_t vpn);
    return ppn_t'({17'd0, vpn} ^ 44'h5A5);
  endfunction

  function automatic page_e rule_size(input vpn_t vpn);
    if (vpn[2][1:0] == 2'd0) begin
      return GibiPage;
    end else if (vpn[2][1:0] == 2'd1) begin
      return MebiPage;
    end
    return KibiPage;
  endfunction

  // Superpages copy the low VPN fields from the request
  function automatic paddr_t rule_paddr(input vaddr_t va);
    ppn_t p;
    p = rule_ppn(va.vpn);
    if (rule_size(va.vpn) == GibiPage) begin
      return {p.p2, va.vpn[1], va.vpn[0], va.page_offset};
    end else if (rule_size(va.vpn) == MebiPage) begin
      return {p.p2, p.p1, va.vpn[0], va.page_offset};
    end
    return {p, va.page_offset};
  endfunction

  function automatic exception_e rule_exception(input vaddr_t va, input priv_e priv);
    if (va.upper != {(XLEN-VADDR_LEN){va.vpn[2][8]}}) begin
      return PageFault;
    end else if (va.vpn[2][8]) begin
      return AccessFault;
    end else if ((priv == U && !va.vpn[2][2]) || (priv == S && va.vpn[2][2])) begin
      return PageFault;
    end
    return NoException;
  endfunction

  function automatic vaddr_t make_vaddr(input vpn_t vpn, input logic bad);
    vaddr_t      va;
    logic [31:0] r;
    r = rand_bits(12);
    va.vpn         = vpn;
    va.page_offset = r[11:0];
    va.upper       = {(XLEN-VADDR_LEN){vpn[2][8]}};
    // Inverted upper bits never match bit 38
    if (bad) begin
      va.upper = ~va.upper;
    end
    return va;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One flush cycle, unit assumed idle
  task automatic flush_tlb(input flush_e kind, input asid_t asid, input vpn_t page);
    flush_type = kind;
    flush_asid = asid;
    flush_page = page;
    @(posedge clk_i);
    #1;
    flush_type = NoFlush;
  endtask

  // Holds the request until the response, entered and left at edge plus 1
  task automatic do_request(input vaddr_t va, input priv_e priv, input logic must_miss,
                            input logic expect_fast, output logic filled);
    int unsigned cycles;
    logic        saw_l2;
    exception_e  exp_exc;
    exp_exc       = rule_exception(va, priv);
    priv_mode     = priv;
    ic_areq.valid = 1'b1;
    ic_areq.vaddr = va;
    cycles        = 0;
    saw_l2        = 1'b0;
    #2;
    while (!ic_aresp.valid) begin
      if (l2_req.valid) begin
        saw_l2 = 1'b1;
        compare("l2_req_o.vpn", 64'(l2_req.vpn), 64'(va.vpn));
      end
      @(posedge clk_i);
      #3;
      cycles++;
    end
    compare("ic_areq_ready_o", 64'(ic_areq_ready), 64'd1);
    compare("ic_aresp_o.exception", 64'(ic_aresp.exception), 64'(exp_exc));
    if (exp_exc == NoException) begin
      compare("ic_aresp_o.hit", 64'(ic_aresp.hit), 64'd1);
      compare("ic_aresp_o.paddr", 64'(ic_aresp.paddr), 64'(rule_paddr(va)));
    end else if (exp_exc == AccessFault) begin
      compare("ic_aresp_o.hit", 64'(ic_aresp.hit), 64'd0);
    end
    if (va.upper != {(XLEN-VADDR_LEN){va.vpn[2][8]}}) begin
      compare("l2_req_o.valid on fault", 64'(saw_l2), 64'd0);
    end
    if (must_miss) begin
      compare("l2_req_o.valid on miss", 64'(saw_l2), 64'd1);
    end
    if (expect_fast) begin
      compare("response latency", 64'(cycles), 64'd0);
      compare("l2_req_o.valid on hit", 64'(saw_l2), 64'd0);
    end
    filled = saw_l2 && (exp_exc != AccessFault);
    @(posedge clk_i);
    #1;
    ic_areq.valid = 1'b0;
  endtask

  // Translation off, answered in the same cycle
  task automatic do_passthrough();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(32);
    lo = rand_bits(32);
    vmem_on       = 1'b0;
    ic_areq.valid = 1'b1;
    ic_areq.vaddr = vaddr_t'({hi, lo});
    #2;
    compare("ic_aresp_o.valid", 64'(ic_aresp.valid), 64'd1);
    compare("ic_aresp_o.hit", 64'(ic_aresp.hit), 64'd1);
    compare("ic_aresp_o.paddr", 64'(ic_aresp.paddr), 64'({hi, lo}) & 64'h00FF_FFFF_FFFF_FFFF);
    compare("ic_aresp_o.exception", 64'(ic_aresp.exception), 64'(NoException));
    compare("l2_req_o.valid", 64'(l2_req.valid), 64'd0);
    @(posedge clk_i);
    #1;
    ic_areq.valid = 1'b0;
    vmem_on       = 1'b1;
  endtask

  // Abort in the wait state, then the late answer must be dropped
  task automatic abort_test(input vpn_t vpn);
    vaddr_t va;
    logic   filled;
    va = make_vaddr(vpn, 1'b0);
    flush_tlb(FlushAll, '0, '0);
    late_mode     = 1'b1;
    priv_mode     = M;
    ic_areq.valid = 1'b1;
    ic_areq.vaddr = va;
    #2;
    while (!l2_resp_ready) begin
      @(posedge clk_i);
      #3;
    end
    @(posedge clk_i);
    #1;
    abort         = 1'b1;
    ic_areq.valid = 1'b0;
    @(posedge clk_i);
    #1;
    abort = 1'b0;
    while (l2_busy) begin
      @(posedge clk_i);
      #1;
    end
    late_mode = 1'b0;
    do_request(va, M, 1'b1, 1'b0, filled);
  endtask

  // Second-level TLB model with random delays
  initial begin : l2_model
    vpn_t        vpn;
    logic [31:0] r;
    l2_req_ready = 1'b0;
    l2_resp      = '0;
    forever begin
      @(posedge clk_i);
      #3;
      if (rst_ni && l2_req.valid) begin
        l2_busy = 1'b1;
        vpn     = l2_req.vpn;
        r       = rand_bits(3);
        repeat (r[2:0]) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        l2_req_ready = 1'b1;
        // Accepted at this edge, the request is still held
        @(posedge clk_i);
        #1;
        l2_req_ready = 1'b0;
        r = rand_bits(3);
        repeat (r[2:0]) begin
          @(posedge clk_i);
          #1;
        end
        if (late_mode) begin
          while (l2_resp_ready) begin
            @(posedge clk_i);
            #1;
          end
        end
        l2_resp.valid     = 1'b1;
        l2_resp.ppn       = rule_ppn(vpn);
        l2_resp.page_type = rule_size(vpn);
        l2_resp.g_bit     = vpn[2][3];
        l2_resp.u_bit     = vpn[2][2];
        l2_resp.exception = vpn[2][8] ? AccessFault : NoException;
        #1;
        if (late_mode) begin
          compare("l2_resp_ready_o after abort", 64'(l2_resp_ready), 64'd0);
        end
        @(posedge clk_i);
        #1;
        l2_resp = '0;
        l2_busy = 1'b0;
      end
    end
  end

  initial begin : stimulus
    vaddr_t      va;
    vaddr_t      last_va;
    logic        have_last;
    logic        filled;
    logic        filled_again;
    logic [31:0] r;
    vpn_t        vpn;
    priv_e       priv;
    rst_ni     = 1'b0;
    priv_mode  = M;
    base_asid  = 16'h0001;
    flush_type = NoFlush;
    flush_asid = '0;
    flush_page = '0;
    vmem_on    = 1'b1;
    abort      = 1'b0;
    ic_areq    = '0;
    have_last  = 1'b0;
    last_va    = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Page pool, about one page in four faults in the second level
    for (int k = 0; k < N_PAGES; k++) begin
      r = rand_bits(27);
      pages[k] = r[26:0];
      r = rand_bits(2);
      pages[k][2][8] = (r == 32'd3);
    end
    for (int unsigned t = 0; t < N_TRANS; t++) begin
      r   = rand_bits(4);
      vpn = pages[r[3:0]];
      r   = rand_bits(2);
      case (r[1:0])
        2'd0:    priv = U;
        2'd2:    priv = M;
        default: priv = S;
      endcase
      r = rand_bits(4);
      case (r[3:0])
        4'd0: begin
          flush_tlb(FlushAll, '0, '0);
          do_request(make_vaddr(vpn, 1'b0), priv, 1'b1, 1'b0, filled);
        end
        4'd1: begin
          if (have_last) begin
            flush_tlb(FlushAsid, base_asid, '0);
            base_asid = base_asid + 16'd1;
            do_request(last_va, priv, !last_va.vpn[2][3], 1'b0, filled);
          end
        end
        4'd2: begin
          do_passthrough();
        end
        4'd3: begin
          abort_test(vpn);
        end
        default: begin
          r  = rand_bits(3);
          va = make_vaddr(vpn, r[2:0] == 3'd0);
          do_request(va, priv, 1'b0, 1'b0, filled);
          // Fresh fill, the same request must hit at once
          if (filled) begin
            do_request(va, priv, 1'b0, 1'b1, filled_again);
            last_va   = va;
            have_last = 1'b1;
          end
        end
      endcase
    end
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Generous bound per transaction
  initial begin : watchdog
    repeat (N_TRANS * 400) @(posedge clk_i);
    $display("Watchdog expired, the transactions did not finish in time");
    $display("Errors: %0d", errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the ITLB testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module itlb_tb -f verilog.f -o itlb_sim \
  > build.log 2>&1 \
  && ./obj_dir/itlb_sim > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

/* tb_clock.sv */
/*
 * Testbench clock generator
 * Free-running clock, starts low
 */

`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* verilog.f */
itlb_pkg.sv
itlb_nru.sv
itlb_cu.sv
itlb_ctrl.sv
itlb_l1.sv
tb_clock.sv
itlb_tb.sv
